// File: pmu.f
verilog/pmu_pkg.sv
verilog/pmu_cmd_decoder.sv
verilog/domain_seq.sv
verilog/pmu_status.sv
verilog/pmu_top.sv
test/tb_pmu_top.sv

// File: Makefile
# Verilator build and run for the power management unit.

VERILATOR  ?= verilator
FILELIST   ?= pmu.f
TOP        ?= tb_pmu_top
RTL_TOP    ?= pmu_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= -Wall
PASS_MSG   ?= TESTS PASSED

RTL_FILES = $(filter verilog/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing --assert --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_pmu_top.sv
`default_nettype none

module tb_pmu_top;

	timeunit 1ns;
	timeprecision 100ps;

	import pmu_pkg::*;

	typedef enum int {EXP_WAKE, EXP_SLEEP, EXP_IGNORED, EXP_ERROR} outcome_t;

	logic CLKIN;
	logic RESETn;
	logic cmd_valid;
	pmu_op_t cmd_op;
	domain_idx_t cmd_domain;
	domain_vec_t power_on;
	domain_vec_t release_clk;
	domain_vec_t release_rst;
	domain_vec_t release_iso;
	logic evt_valid;
	domain_idx_t evt_domain;
	logic evt_awake;
	domain_vec_t awake_mask;
	logic cmd_error;

	// expected column comes from the domain model.
	pmu_op_t tbl_op[$];
	int tbl_dom[$];
	bit tbl_gap[$];
	outcome_t tbl_exp[$];
	bit table_ready = 1'b0;

	int cyc = 0; // rising edges so far.
	outcome_t last_op [NUM_DOMAINS];
	int last_c [NUM_DOMAINS];
	int seen_c [NUM_DOMAINS];
	bit seen_dir [NUM_DOMAINS];
	bit pend_dir [NUM_DOMAINS];
	domain_vec_t pend = '0;
	bit err_at [int];
	bit exp_evt_valid = 1'b0;
	int exp_evt_domain = 0;
	bit exp_evt_awake = 1'b0;
	int checks = 0;
	int mismatches = 0;
	int evt_seen = 0;
	int trans_exp = 0;
	int last_cmd_c = 0;
	int unsigned lcg_state = 82;

	pmu_top i_pmu_top (
		.CLKIN       (CLKIN),
		.RESETn      (RESETn),
		.cmd_valid   (cmd_valid),
		.cmd_op      (cmd_op),
		.cmd_domain  (cmd_domain),
		.power_on    (power_on),
		.release_clk (release_clk),
		.release_rst (release_rst),
		.release_iso (release_iso),
		.evt_valid   (evt_valid),
		.evt_domain  (evt_domain),
		.evt_awake   (evt_awake),
		.awake_mask  (awake_mask),
		.cmd_error   (cmd_error)
	);

	initial
	begin
		CLKIN = 1'b0;
		forever #2 CLKIN = ~CLKIN;
	end

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic add_row(input pmu_op_t op, input int dom, input bit rand_gap);
		tbl_op.push_back(op);
		tbl_dom.push_back(dom);
		tbl_gap.push_back(rand_gap);
	endtask

	// walks the table with an off/awake flag per domain.
	task automatic fill_expected;
		bit up [NUM_DOMAINS] = '{default: 1'b0};
		for (int r = 0; r < tbl_op.size(); r++)
		begin
			if (tbl_dom[r] >= NUM_DOMAINS)
				tbl_exp.push_back(EXP_ERROR);
			else if ((tbl_op[r] == OP_WAKE) == up[tbl_dom[r]])
				tbl_exp.push_back(EXP_IGNORED);
			else
			begin
				tbl_exp.push_back((tbl_op[r] == OP_WAKE) ? EXP_WAKE : EXP_SLEEP);
				up[tbl_dom[r]] = (tbl_op[r] == OP_WAKE);
				trans_exp++;
			end
		end
	endtask

	task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] want);
		checks++;
		assert (got === want)
		else
		begin
			mismatches++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	// lowest pending domain goes out, then this edge's ready changes join.
	task automatic advance_events;
		int g;
		g = -1;
		for (int d = NUM_DOMAINS - 1; d >= 0; d--)
			if (pend[d])
				g = d;
		exp_evt_valid = (g >= 0);
		if (g >= 0)
		begin
			exp_evt_domain = g;
			exp_evt_awake = pend_dir[g];
			pend[g] = 1'b0;
		end
		for (int d = 0; d < NUM_DOMAINS; d++)
		begin
			if (seen_c[d] == cyc)
			begin
				pend[d] = 1'b1;
				pend_dir[d] = seen_dir[d];
			end
		end
	endtask

	// h counts half cycles and is even just after a rising edge.
	task automatic compare_outputs(input int h);
		domain_vec_t e_pwr;
		domain_vec_t e_clk;
		domain_vec_t e_rst;
		domain_vec_t e_iso;
		domain_vec_t e_mask;
		int c;
		e_pwr = '0;
		e_clk = '0;
		e_rst = '0;
		e_iso = '0;
		e_mask = '0;
		for (int d = 0; d < NUM_DOMAINS; d++)
		begin
			c = last_c[d];
			if (last_op[d] == EXP_WAKE)
			begin
				e_pwr[d] = (h >= 2 * c + 2); // after C+1.
				e_clk[d] = (h >= 2 * c + 3);
				e_rst[d] = (h >= 2 * c + 4);
				e_iso[d] = (h >= 2 * c + 5);
				e_mask[d] = (h >= 2 * c + 8); // ready seen at C+4.
			end
			else if (last_op[d] == EXP_SLEEP)
			begin
				e_iso[d] = (h < 2 * c + 2);
				e_pwr[d] = (h < 2 * c + 3);
				e_clk[d] = e_pwr[d];
				e_rst[d] = e_pwr[d];
				e_mask[d] = (h < 2 * c + 4);
			end
		end
		check_value("power_on", 8'(power_on), 8'(e_pwr));
		check_value("release_clk", 8'(release_clk), 8'(e_clk));
		check_value("release_rst", 8'(release_rst), 8'(e_rst));
		check_value("release_iso", 8'(release_iso), 8'(e_iso));
		check_value("awake_mask", 8'(awake_mask), 8'(e_mask));
		check_value("cmd_error", 8'(cmd_error), 8'(err_at.exists(h / 2)));
		check_value("evt_valid", 8'(evt_valid), 8'(exp_evt_valid));
		if (exp_evt_valid)
		begin
			check_value("evt_domain", 8'(evt_domain), 8'(exp_evt_domain));
			check_value("evt_awake", 8'(evt_awake), 8'(exp_evt_awake));
		end
		if ((h % 2 == 0) && (evt_valid === 1'b1))
			evt_seen++;
	endtask

	// called just after a falling edge.
	task automatic issue_command(input int r);
		int c;
		int d;
		c = cyc + 1; // rising edge that samples it.
		d = tbl_dom[r];
		cmd_valid = 1'b1;
		cmd_op = tbl_op[r];
		cmd_domain = domain_idx_t'(d);
		last_cmd_c = c;
		case (tbl_exp[r])
			EXP_ERROR:
				err_at[c] = 1'b1;
			EXP_WAKE, EXP_SLEEP:
			begin
				last_op[d] = tbl_exp[r];
				last_c[d] = c;
				seen_c[d] = (tbl_exp[r] == EXP_WAKE) ? c + 4 : c + 2;
				seen_dir[d] = (tbl_exp[r] == EXP_WAKE);
			end
			default: ;
		endcase
		@(negedge CLKIN);
		cmd_valid = 1'b0;
	endtask

	initial
	begin
		forever
		begin
			@(posedge CLKIN);
			cyc++;
			advance_events();
			#1;
			compare_outputs(2 * cyc);
			@(negedge CLKIN);
			#1;
			compare_outputs(2 * cyc + 1);
		end
	end

	initial
	begin
		int limit;
		wait (table_ready);
		limit = tbl_op.size() * 20 + 16;
		repeat (limit) @(posedge CLKIN);
		$display("error: run did not finish within %0d cycles", limit);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		RESETn = 1'b0;
		cmd_valid = 1'b0;
		cmd_op = OP_WAKE;
		cmd_domain = '0;
		for (int d = 0; d < NUM_DOMAINS; d++)
		begin
			last_op[d] = EXP_IGNORED;
			last_c[d] = -10;
			seen_c[d] = -1;
		end
		add_row(OP_WAKE, 0, 1);
		add_row(OP_WAKE, 0, 1);
		add_row(OP_SLEEP, 0, 1);
		add_row(OP_SLEEP, 0, 1);
		add_row(OP_WAKE, 6, 1);
		add_row(OP_WAKE, 1, 0); // three wakes back to back.
		add_row(OP_WAKE, 2, 0);
		add_row(OP_WAKE, 3, 1);
		add_row(OP_WAKE, 5, 1);
		add_row(OP_WAKE, 4, 0); // 4 and 1 change on the same edge.
		add_row(OP_WAKE, 7, 0);
		add_row(OP_SLEEP, 1, 1);
		add_row(OP_SLEEP, 6, 1);
		add_row(OP_WAKE, 0, 0);
		add_row(OP_SLEEP, 5, 0);
		add_row(OP_SLEEP, 3, 1);
		add_row(OP_WAKE, 2, 1);
		add_row(OP_SLEEP, 2, 1);
		add_row(OP_SLEEP, 4, 1);
		fill_expected();
		table_ready = 1'b1;
		repeat (16) @(negedge CLKIN);
		RESETn = 1'b1;
		repeat (3) @(negedge CLKIN);
		for (int r = 0; r < tbl_op.size(); r++)
		begin
			// let an earlier transition of the same domain finish.
			if (tbl_dom[r] < NUM_DOMAINS)
				while ((cyc <= last_c[tbl_dom[r]] + 4) || pend[tbl_dom[r]])
					@(negedge CLKIN);
			issue_command(r);
			if (tbl_gap[r])
			begin
				lcg_state = lcg_next(lcg_state);
				repeat ((lcg_state >> 16) % 8) @(negedge CLKIN);
			end
		end
		while ((cyc <= last_cmd_c + 6) || (pend != '0))
			@(negedge CLKIN);
		repeat (4) @(negedge CLKIN);
		assert (evt_seen == trans_exp)
		else
		begin
			mismatches++;
			$display("mismatch at %0t: %0d events seen, expected %0d", $time, evt_seen, trans_exp);
		end
		$display("checks %0d, mismatches %0d", checks, mismatches);
		if (mismatches == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/pmu_top.sv
`default_nettype none

module pmu_top (
	input  wire                        CLKIN,
	input  wire                        RESETn,
	input  wire                        cmd_valid,
	input  wire pmu_pkg::pmu_op_t      cmd_op,
	input  wire pmu_pkg::domain_idx_t  cmd_domain,
	output wire pmu_pkg::domain_vec_t  power_on,
	output wire pmu_pkg::domain_vec_t  release_clk,
	output wire pmu_pkg::domain_vec_t  release_rst,
	output wire pmu_pkg::domain_vec_t  release_iso,
	output wire                        evt_valid,
	output wire pmu_pkg::domain_idx_t  evt_domain,
	output wire                        evt_awake,
	output wire pmu_pkg::domain_vec_t  awake_mask,
	output wire                        cmd_error
);

	import pmu_pkg::*;

	domain_vec_t wake_req;
	domain_vec_t sleep_req;
	wire domain_vec_t ready_vec;

	pmu_cmd_decoder i_pmu_cmd_decoder (
		.CLKIN      (CLKIN),
		.RESETn     (RESETn),
		.cmd_valid  (cmd_valid),
		.cmd_op     (cmd_op),
		.cmd_domain (cmd_domain),
		.wake_req   (wake_req),
		.sleep_req  (sleep_req),
		.cmd_error  (cmd_error)
	);

	// one sequencer per gated layer.
	for (genvar g = 0; g < NUM_DOMAINS; g++)
	begin : g_domain
		domain_seq i_domain_seq (
			.CLKIN       (CLKIN),
			.RESETn      (RESETn),
			.wake_req    (wake_req[g]),
			.sleep_req   (sleep_req[g]),
			.power_on    (power_on[g]),
			.release_clk (release_clk[g]),
			.release_rst (release_rst[g]),
			.release_iso (release_iso[g]),
			.ready       (ready_vec[g])
		);
	end

	pmu_status i_pmu_status (
		.CLKIN      (CLKIN),
		.RESETn     (RESETn),
		.ready_vec  (ready_vec),
		.evt_valid  (evt_valid),
		.evt_domain (evt_domain),
		.evt_awake  (evt_awake),
		.awake_mask (awake_mask)
	);

endmodule

`default_nettype wire

// File: verilog/pmu_status.sv
`default_nettype none

module pmu_status (
	input  wire                       CLKIN,
	input  wire                       RESETn,
	input  wire pmu_pkg::domain_vec_t ready_vec,
	output logic                      evt_valid,
	output pmu_pkg::domain_idx_t      evt_domain,
	output logic                      evt_awake,
	output pmu_pkg::domain_vec_t      awake_mask
);

	import pmu_pkg::*;

	domain_vec_t ready_q;
	domain_vec_t change;
	domain_vec_t pending;
	domain_vec_t dir; // ready level at the last change.
	domain_vec_t grant;
	domain_idx_t grant_idx;

	assign change = ready_vec ^ ready_q;
	assign awake_mask = ready_q;

	// lowest pending domain wins.
	always_comb
	begin
		grant = '0;
		grant_idx = '0;
		for (int i = 0; i < NUM_DOMAINS; i++)
		begin
			if (pending[i] && (grant == '0))
			begin
				grant[i] = 1'b1;
				grant_idx = domain_idx_t'(i);
			end
		end
	end

	always_ff @(posedge CLKIN or negedge RESETn)
	begin
		if (!RESETn)
		begin
			ready_q <= '0;
			pending <= '0;
			evt_valid <= 1'b0;
		end
		else
		begin
			ready_q <= ready_vec;
			pending <= (pending & ~grant) | change; // a new change survives its grant.
			evt_valid <= |pending;
		end
	end

	always_ff @(posedge CLKIN)
	begin
		dir <= (dir & ~change) | (ready_vec & change);
		if (|pending)
		begin
			evt_domain <= grant_idx;
			evt_awake <= |(dir & grant);
		end
	end

	a_evt_domain_range: assert property (
		@(posedge CLKIN) disable iff (!RESETn)
		evt_valid |-> (evt_domain < domain_idx_t'(NUM_DOMAINS))
	);

endmodule

`default_nettype wire

// File: verilog/domain_seq.sv
`default_nettype none

module domain_seq (
	input  wire  CLKIN,
	input  wire  RESETn,
	input  wire  wake_req,
	input  wire  sleep_req,
	output logic power_on,
	output logic release_clk,
	output logic release_rst,
	output logic release_iso,
	output logic ready
);

	import pmu_pkg::*;

	seq_pos_t pos_state;
	seq_neg_t neg_state;

	logic power_on_pos;
	logic power_on_neg;
	logic release_clk_pos;
	logic release_clk_neg;
	logic release_rst_pos;
	logic release_rst_neg;
	logic release_iso_pos;
	logic release_iso_neg;

	// either half holding keeps the output held.
	always_comb
	begin
		power_on = ((power_on_pos == HOLD) || (power_on_neg == HOLD)) ? HOLD : RELEASE;
		release_clk = ((release_clk_pos == HOLD) || (release_clk_neg == HOLD)) ? HOLD : RELEASE;
		release_rst = ((release_rst_pos == HOLD) || (release_rst_neg == HOLD)) ? HOLD : RELEASE;
		release_iso = ((release_iso_pos == HOLD) || (release_iso_neg == HOLD)) ? HOLD : RELEASE;
	end

	always_ff @(posedge CLKIN or negedge RESETn)
	begin
		if (!RESETn)
		begin
			pos_state <= POS_OFF;
			power_on_pos <= HOLD;
			release_clk_pos <= HOLD;
			release_rst_pos <= HOLD;
			release_iso_pos <= HOLD;
			ready <= 1'b0;
		end
		else
		begin
			case (pos_state)
				POS_OFF:
				begin
					if (wake_req) // stays off otherwise.
					begin
						power_on_pos <= RELEASE;
						release_clk_pos <= RELEASE;
						release_iso_pos <= RELEASE;
						pos_state <= POS_POWER;
					end
				end

				POS_POWER:
				begin
					release_rst_pos <= RELEASE; // clock is already running.
					pos_state <= POS_RUN;
				end

				POS_RUN:
				begin
					if (sleep_req)
					begin
						release_iso_pos <= HOLD;
						ready <= 1'b0;
						pos_state <= POS_ISOLATE;
					end
					else
						ready <= 1'b1;
				end

				POS_ISOLATE:
				begin
					// neg half holds these since the last falling edge.
					power_on_pos <= HOLD;
					release_clk_pos <= HOLD;
					release_rst_pos <= HOLD;
					pos_state <= POS_OFF;
				end

				default:
					pos_state <= POS_OFF;
			endcase
		end
	end

	always_ff @(negedge CLKIN or negedge RESETn)
	begin
		if (!RESETn)
		begin
			neg_state <= NEG_IDLE;
			power_on_neg <= RELEASE;
			release_clk_neg <= HOLD;
			release_rst_neg <= RELEASE;
			release_iso_neg <= HOLD;
		end
		else
		begin
			case (neg_state)
				NEG_IDLE:
				begin
					if (pos_state == POS_POWER)
					begin
						release_clk_neg <= RELEASE; // half a cycle after power.
						neg_state <= NEG_CLOCK;
					end
					else
					begin
						power_on_neg <= RELEASE;
						release_clk_neg <= HOLD;
						release_rst_neg <= RELEASE;
						release_iso_neg <= HOLD;
					end
				end

				NEG_CLOCK:
				begin
					release_iso_neg <= RELEASE; // follows reset release.
					neg_state <= NEG_ON;
				end

				NEG_ON:
				begin
					if (pos_state == POS_ISOLATE)
					begin
						power_on_neg <= HOLD;
						release_clk_neg <= HOLD;
						release_rst_neg <= HOLD;
						neg_state <= NEG_IDLE;
					end
				end

				default:
					neg_state <= NEG_IDLE;
			endcase
		end
	end

	// outputs come from both halves, so check on both edges.
	a_iso_needs_power: assert property (
		@(CLKIN) disable iff (!RESETn)
		(release_iso == RELEASE) |-> (power_on == RELEASE)
	);

	a_rst_needs_clk: assert property (
		@(CLKIN) disable iff (!RESETn)
		(release_rst == RELEASE) |-> (release_clk == RELEASE)
	);

endmodule

`default_nettype wire

// File: verilog/pmu_cmd_decoder.sv
`default_nettype none

module pmu_cmd_decoder (
	input  wire                   CLKIN,
	input  wire                   RESETn,
	input  wire                   cmd_valid,
	input  wire pmu_pkg::pmu_op_t     cmd_op,
	input  wire pmu_pkg::domain_idx_t cmd_domain,
	output pmu_pkg::domain_vec_t  wake_req,
	output pmu_pkg::domain_vec_t  sleep_req,
	output logic                  cmd_error
);

	import pmu_pkg::*;

	logic in_range;
	domain_vec_t sel_vec;

	assign in_range = (cmd_domain < domain_idx_t'(NUM_DOMAINS));

	// one-hot of the target, empty when out of range.
	assign sel_vec = in_range ? (domain_vec_t'(1) << cmd_domain) : '0;

	always_ff @(posedge CLKIN or negedge RESETn)
	begin
		if (!RESETn)
		begin
			wake_req <= '0;
			sleep_req <= '0;
			cmd_error <= 1'b0;
		end
		else
		begin
			if (cmd_valid && (cmd_op == OP_WAKE))
				wake_req <= sel_vec;
			else
				wake_req <= '0;

			if (cmd_valid && (cmd_op == OP_SLEEP))
				sleep_req <= sel_vec;
			else
				sleep_req <= '0;

			cmd_error <= cmd_valid && !in_range; // bad index strobe.
		end
	end

	// a domain is never asked to wake and sleep at once.
	a_req_exclusive: assert property (
		@(posedge CLKIN) disable iff (!RESETn)
		(wake_req & sleep_req) == '0
	);

endmodule

`default_nettype wire

// File: verilog/pmu_pkg.sv
`default_nettype none

package pmu_pkg;

	// gated layers under control.
	localparam int NUM_DOMAINS = 6;
	localparam int DOMAIN_IDX_W = 3;

	typedef logic [DOMAIN_IDX_W-1:0] domain_idx_t; // 6 and 7 name nothing.
	typedef logic [NUM_DOMAINS-1:0] domain_vec_t;

	typedef logic pmu_op_t;

	localparam pmu_op_t OP_WAKE = 1'b0;
	localparam pmu_op_t OP_SLEEP = 1'b1;

	// every control output is high when released.
	localparam logic HOLD = 1'b0;
	localparam logic RELEASE = 1'b1;

	// rising-edge half.
	typedef enum logic [1:0]
	{
		POS_OFF,
		POS_POWER,
		POS_RUN,
		POS_ISOLATE
	} seq_pos_t;

	// falling-edge half.
	typedef enum logic [1:0]
	{
		NEG_IDLE,
		NEG_CLOCK,
		NEG_ON
	} seq_neg_t;

endpackage

`default_nettype wire
